// ==== verilog/ternary_pkg.sv ====
// shared sizes, weight code limits and width types for the ternary matmul, imported by every RTL module
package ternary_pkg;

    // five ternary weights fit in one byte since 3^5 = 243
    localparam int lanes = 5;

    // weight bytes and activations that make up one block
    localparam int slices = 2;

    // strobe counter width, never narrower than one bit
    localparam int slice_bits = (slices > 1) ? $clog2(slices) : 1;

    // one accumulator row per weight in the block
    localparam int rows = lanes * slices;

    // one column per activation in the block
    localparam int acc_count = rows * slices;

    // highest code that is a proper base-3 number
    localparam int max_weight_code = 242;

    // lowest accumulator bit that reaches the result byte
    localparam int result_shift = 8;

    // packed base-3 weight byte as it arrives on the input
    typedef logic [7:0] weight_code_t;

    // one bit per lane of a single weight byte
    typedef logic [lanes-1:0] lane_mask_t;

    // one bit per row of a whole block
    typedef logic [rows-1:0] row_mask_t;

    // signed input activation
    typedef logic signed [7:0] activation_t;

    // accumulator with headroom for long runs of blocks
    typedef logic signed [16:0] acc_t;

    // all accumulators side by side, entry n at bits n*17 upward
    typedef logic [acc_count*$bits(acc_t)-1:0] acc_grid_t;

    // output byte taken from the middle of an accumulator
    typedef logic [7:0] result_t;

endpackage

// ==== verilog/ternary_unpack.sv ====
// combinational base-3 decoder that turns one weight byte into zero and sign masks per lane
`timescale 1ns/100ps

module ternary_unpack (
    input  ternary_pkg::weight_code_t weight_code,
    output ternary_pkg::lane_mask_t   lane_zero,
    output ternary_pkg::lane_mask_t   lane_sign
);
    import ternary_pkg::*;

    // running quotient while digits are peeled off
    weight_code_t quotient;

    // current base-3 digit
    logic [1:0] digit;

    // codes 243..255 have no base-3 meaning
    logic code_valid;

    assign code_valid = (weight_code <= weight_code_t'(max_weight_code));

    // least significant digit belongs to lane 4
    // most significant digit ends up in lane 0
    always_comb begin
        quotient  = weight_code;
        digit     = 2'd0;
        lane_zero = '0;
        lane_sign = '0;
        for (int lane = lanes - 1; lane >= 0; lane--) begin
            // divide by three with a constant divisor
            digit    = 2'(quotient % 3);
            quotient = weight_code_t'(quotient / 3);
            // digit 0 is a zero weight
            lane_zero[lane] = (digit == 2'd0);
            // digit 2 is a minus one weight
            lane_sign[lane] = (digit == 2'd2);
        end
        // out of range codes fall back to all masks clear
        // which reads as five +1 weights downstream
        if (!code_valid) begin
            lane_zero = '0;
            lane_sign = '0;
        end
    end

    // mask encoding per lane
    //   zero=1 sign=x  weight 0
    //   zero=0 sign=0  weight +1
    //   zero=0 sign=1  weight -1
    // sign is only set together with a nonzero weight
    // so a zero lane always has sign clear

endmodule

// ==== verilog/block_gatherer.sv ====
// gathers slices strobed weight masks and activations and hands each full block to the MAC array
`timescale 1ns/100ps

module block_gatherer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic                       read_out,
    input  ternary_pkg::lane_mask_t    lane_zero,
    input  ternary_pkg::lane_mask_t    lane_sign,
    input  ternary_pkg::activation_t   activation,
    output ternary_pkg::row_mask_t     block_zero,
    output ternary_pkg::row_mask_t     block_sign,
    output logic [ternary_pkg::slices*$bits(ternary_pkg::activation_t)-1:0] block_acts,
    output logic                       block_load
);
    import ternary_pkg::*;

    // strobes seen so far in the current block
    logic [slice_bits-1:0] strobe_count;

    // the strobe in this cycle closes the block
    logic last_strobe;

    assign last_strobe = (strobe_count == slice_bits'(slices - 1));

    // strobe counter and block_load pulse
    always_ff @(posedge clk) begin
        if (reset || read_out) begin
            // partial block is dropped on readout
            strobe_count <= '0;
            block_load   <= 1'b0;
        end else begin
            // one cycle pulse after the closing strobe
            block_load <= in_valid && last_strobe;
            if (in_valid) begin
                if (last_strobe) begin
                    strobe_count <= '0;
                end else begin
                    strobe_count <= strobe_count + 1'b1;
                end
            end
        end
    end

    // next-block registers
    // newest strobe enters at the top and older ones move down
    // so after a full block strobe s sits in rows s*lanes upward
    // and its activation sits in column s
    always_ff @(posedge clk) begin
        if (in_valid) begin
            block_zero <= {lane_zero, block_zero[rows-1:lanes]};
            block_sign <= {lane_sign, block_sign[rows-1:lanes]};
            block_acts <= {activation,
                           block_acts[slices*$bits(activation_t)-1:$bits(activation_t)]};
        end
    end

    // the MAC array copies these registers on block_load
    // a strobe in the same cycle only changes them after that copy
    // which is why back to back blocks need no stall

endmodule

// ==== verilog/mac_array.sv ====
// MAC array that rotates each accumulator row past a single ternary adder, one column per cycle
`timescale 1ns/100ps

module mac_array (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    block_load,
    input  logic                    read_out,
    input  ternary_pkg::row_mask_t  block_zero,
    input  ternary_pkg::row_mask_t  block_sign,
    input  logic [ternary_pkg::slices*$bits(ternary_pkg::activation_t)-1:0] block_acts,
    output ternary_pkg::acc_grid_t  acc_values
);
    import ternary_pkg::*;

    // block being applied
    row_mask_t cur_zero;
    row_mask_t cur_sign;
    logic [slices*$bits(activation_t)-1:0] cur_acts;

    // apply window control
    logic apply_active;
    logic [slice_bits-1:0] apply_col;

    // accumulator grid, entry r*slices+c is row r column c
    acc_t acc_cells [acc_count];

    // compute end of each row
    acc_t head_sum [rows];
    activation_t head_act;
    acc_t addend;

    // head activation always sits in the low byte
    assign head_act = cur_acts[$bits(activation_t)-1:0];
    // sign extend once for all rows
    assign addend = head_act;

    // window opens on block_load and lasts slices cycles
    // a new block_load restarts it even in its last cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            apply_active <= 1'b0;
            apply_col    <= '0;
        end else if (block_load) begin
            apply_active <= 1'b1;
            apply_col    <= '0;
        end else if (apply_active) begin
            apply_active <= (apply_col != slice_bits'(slices - 1));
            apply_col    <= apply_col + 1'b1;
        end
    end

    // operand copy, then activations step down one column per cycle
    always_ff @(posedge clk) begin
        if (block_load) begin
            cur_zero <= block_zero;
            cur_sign <= block_sign;
            cur_acts <= block_acts;
        end else if (apply_active) begin
            cur_acts <= cur_acts >> $bits(activation_t);
        end
    end

    // ternary multiply is add, subtract or pass
    always_comb begin
        for (int r = 0; r < rows; r++) begin
            if (cur_zero[r]) begin
                head_sum[r] = acc_cells[r*slices];
            end else if (cur_sign[r]) begin
                head_sum[r] = acc_cells[r*slices] - addend;
            end else begin
                head_sum[r] = acc_cells[r*slices] + addend;
            end
        end
    end

    // column 0 leaves through the adder and re-enters at the far end
    // after slices steps every cell is back in its home column
    always_ff @(posedge clk) begin
        if (reset || read_out) begin
            for (int n = 0; n < acc_count; n++) begin
                acc_cells[n] <= '0;
            end
        end else if (apply_active) begin
            for (int r = 0; r < rows; r++) begin
                for (int c = 0; c < slices - 1; c++) begin
                    acc_cells[r*slices+c] <= acc_cells[r*slices+c+1];
                end
                acc_cells[r*slices+slices-1] <= head_sum[r];
            end
        end
    end

    // flatten for the readout queue
    always_comb begin
        for (int n = 0; n < acc_count; n++) begin
            acc_values[n*$bits(acc_t) +: $bits(acc_t)] = acc_cells[n];
        end
    end

endmodule

// ==== verilog/readout_queue.sv ====
// output queue that snapshots all accumulators on read_out and streams one result byte per cycle
`timescale 1ns/100ps

module readout_queue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    read_out,
    input  ternary_pkg::acc_grid_t  acc_values,
    output ternary_pkg::result_t    result
);
    import ternary_pkg::*;

    // queue entries, entry 0 drives the output
    acc_t queue [acc_count];

    // snapshot on read_out, otherwise move toward entry 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < acc_count; n++) begin
                queue[n] <= '0;
            end
        end else if (read_out) begin
            // entry n is row n/slices, column n%slices
            for (int n = 0; n < acc_count; n++) begin
                queue[n] <= acc_values[n*$bits(acc_t) +: $bits(acc_t)];
            end
        end else begin
            for (int n = 0; n < acc_count - 1; n++) begin
                queue[n] <= queue[n+1];
            end
            // drained queue reads back as zero
            queue[acc_count-1] <= '0;
        end
    end

    // entry 0 appears in the cycle after the read_out edge
    // scaled down by 256 and truncated to a byte
    assign result = queue[0][result_shift +: $bits(result_t)];

    // bit 16 is dropped here
    // so large sums wrap rather than saturate

endmodule

// ==== verilog/ternary_matmul_top.sv ====
// top level of the ternary matmul, wiring the decoder, block gatherer, MAC array and readout queue
`timescale 1ns/100ps

module ternary_matmul_top (
    input  logic                       clk,
    input  logic                       reset,
    input  ternary_pkg::weight_code_t  weight_code,
    input  ternary_pkg::activation_t   activation,
    input  logic                       in_valid,
    input  logic                       read_out,
    output ternary_pkg::result_t       result
);
    import ternary_pkg::*;

    // decoded masks of the byte on the input
    lane_mask_t lane_zero;
    lane_mask_t lane_sign;

    // complete block from the gatherer
    row_mask_t block_zero;
    row_mask_t block_sign;
    logic [slices*$bits(activation_t)-1:0] block_acts;
    logic block_load;

    // accumulator grid toward the queue
    acc_grid_t acc_values;

    // byte to masks
    ternary_unpack i_ternary_unpack (
        .weight_code (weight_code),
        .lane_zero   (lane_zero),
        .lane_sign   (lane_sign)
    );

    // strobes to blocks
    block_gatherer i_block_gatherer (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .read_out   (read_out),
        .lane_zero  (lane_zero),
        .lane_sign  (lane_sign),
        .activation (activation),
        .block_zero (block_zero),
        .block_sign (block_sign),
        .block_acts (block_acts),
        .block_load (block_load)
    );

    // blocks into the accumulators
    mac_array i_mac_array (
        .clk        (clk),
        .reset      (reset),
        .block_load (block_load),
        .read_out   (read_out),
        .block_zero (block_zero),
        .block_sign (block_sign),
        .block_acts (block_acts),
        .acc_values (acc_values)
    );

    // accumulators out as bytes
    readout_queue i_readout_queue (
        .clk        (clk),
        .reset      (reset),
        .read_out   (read_out),
        .acc_values (acc_values),
        .result     (result)
    );

endmodule

// ==== tests/ternary_tb_model.svh ====
// reference model of decoding and accumulation plus the value check, included inside the testbench module
`ifndef TERNARY_TB_MODEL_SVH
`define TERNARY_TB_MODEL_SVH

// check bookkeeping
int check_count = 0;
int error_count = 0;

// model accumulators, entry r*slices+c is row r column c
acc_t model_acc [acc_count];

// expected bytes of the readout in flight
// two extra entries for the drained queue
result_t expect_bytes [acc_count+2];

// ternary weight of one lane of a code, as -1, 0 or +1
function automatic int lane_weight(input weight_code_t code, input int lane);
    int place;
    int digit;
    place = 1;
    // lane 4 is the units digit, lane 0 the 81s digit
    for (int k = lane; k < lanes - 1; k++) begin
        place = place * 3;
    end
    digit = (int'(code) / place) % 3;
    if (int'(code) > max_weight_code) begin
        // codes past 3^5-1 read as +1 on every lane
        lane_weight = 1;
    end else if (digit == 1) begin
        lane_weight = 1;
    end else if (digit == 2) begin
        lane_weight = -1;
    end else begin
        lane_weight = 0;
    end
endfunction

// add the outer product of one block into the model
// row r takes lane r%lanes of strobe r/lanes
// column c takes the activation of strobe c
function automatic void accumulate_block();
    int w;
    int prod;
    for (int r = 0; r < rows; r++) begin
        w = lane_weight(pend_codes[r / lanes], r % lanes);
        for (int c = 0; c < slices; c++) begin
            prod = w * int'(pend_acts[c]);
            // 17 bit wraparound like the hardware
            model_acc[r*slices+c] = acc_t'(model_acc[r*slices+c] + acc_t'(prod));
        end
    end
endfunction

// zero all model accumulators
function automatic void clear_model();
    for (int n = 0; n < acc_count; n++) begin
        model_acc[n] = '0;
    end
endfunction

// freeze the expected readout and clear the model
// as read_out clears the hardware accumulators
function automatic void capture_expected();
    for (int n = 0; n < acc_count; n++) begin
        // byte above the fractional part
        expect_bytes[n] = model_acc[n][15:8];
    end
    // drained queue shows zero
    expect_bytes[acc_count]   = '0;
    expect_bytes[acc_count+1] = '0;
    clear_model();
endfunction

// compare one value, report and count a mismatch
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    check_count++;
    // an X or Z from the DUT is a mismatch too
    if (got !== expected) begin
        error_count++;
        $display("CHECK FAILED at time %0t: %s is %0h, expected %0h",
                 $time, name, got, expected);
    end
endtask

`endif

// ==== tests/ternary_matmul_tb.sv ====
// self-checking testbench for the ternary matmul top level, compiled from vlog.f with this module on top
`timescale 1ns/100ps

module ternary_matmul_tb;
    import ternary_pkg::*;

    // clock and test lengths
    localparam int clk_period     = 40;
    localparam int reset_cycles   = 16;
    localparam int repeat_blocks  = 256;
    localparam int decode_rounds  = 8;
    localparam int random_blocks  = 200;
    localparam int max_gap        = 2;
    localparam int invalid_rounds = 7;
    localparam int burst_blocks   = 100;

    // idle wait, read_out pulse, queue drain and some slack
    localparam int readout_cycles = slices + 3 + acc_count + 8;

    // cycle budget per test, summed for the watchdog
    localparam int total_cycles =
        (reset_cycles + acc_count + 2) +
        decode_rounds * (repeat_blocks * slices + readout_cycles) +
        (random_blocks * (slices + max_gap) + readout_cycles) +
        (3 * readout_cycles + 2 * slices) +
        invalid_rounds * (repeat_blocks * slices + readout_cycles) +
        (burst_blocks * slices + readout_cycles);

    // DUT ports
    logic         clk;
    logic         reset;
    weight_code_t weight_code;
    activation_t  activation;
    logic         in_valid;
    logic         read_out;
    result_t      result;

    // random seed
    integer seed;

    // block about to be sent
    weight_code_t pend_codes [slices];
    activation_t  pend_acts [slices];

    // handoff to the compare process
    event compare_start;
    logic compare_busy;

    // per test reporting
    int test_count;
    int errors_before;

    `include "ternary_tb_model.svh"

    ternary_matmul_top i_ternary_matmul_top (
        .clk         (clk),
        .reset       (reset),
        .weight_code (weight_code),
        .activation  (activation),
        .in_valid    (in_valid),
        .read_out    (read_out),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // one strobe, driven on the falling edge
    // in_valid stays high until idle_cycles drops it
    task automatic drive_strobe(input weight_code_t code, input activation_t act);
        @(negedge clk);
        weight_code = code;
        activation  = act;
        in_valid    = 1'b1;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // codes drawn from lo..lo+span-1, any activation
    task automatic fill_random_block(input int lo, input int span);
        for (int s = 0; s < slices; s++) begin
            pend_codes[s] = weight_code_t'(lo + $unsigned($random(seed)) % span);
            pend_acts[s]  = activation_t'($random(seed));
        end
    endtask

    // full block into the DUT and into the model
    task automatic send_block();
        for (int s = 0; s < slices; s++) begin
            drive_strobe(pend_codes[s], pend_acts[s]);
        end
        accumulate_block();
    endtask

    // let the MAC window close, pulse read_out, wait for the compare
    task automatic run_readout();
        idle_cycles(slices + 3);
        capture_expected();
        @(negedge clk);
        read_out     = 1'b1;
        compare_busy = 1'b1;
        -> compare_start;
        @(negedge clk);
        read_out = 1'b0;
        wait (!compare_busy);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %0d %s done, %0d errors", test_count, name,
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    // samples each queue byte on the falling edge after it appears
    initial begin : compare_results
        forever begin
            @(compare_start);
            for (int n = 0; n < acc_count + 2; n++) begin
                @(negedge clk);
                check_value($sformatf("result[%0d]", n), result, expect_bytes[n]);
            end
            compare_busy = 1'b0;
        end
    end

    initial begin : watchdog
        #(total_cycles * 2 * clk_period);
        $display("watchdog expired, the tests did not finish within %0d cycles",
                 total_cycles * 2);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        seed          = 32'h7d3f;
        reset         = 1'b1;
        weight_code   = '0;
        activation    = '0;
        in_valid      = 1'b0;
        read_out      = 1'b0;
        compare_busy  = 1'b0;
        test_count    = 0;
        errors_before = 0;
        clear_model();
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        // quiet output after reset
        repeat (acc_count + 2) begin
            @(negedge clk);
            check_value("result", result, '0);
        end
        finish_test("reset");

        // 256 repeats scale weight times activation into bits 15:8
        for (int i = 0; i < decode_rounds; i++) begin
            fill_random_block(0, max_weight_code + 1);
            repeat (repeat_blocks) send_block();
            run_readout();
        end
        finish_test("decode");

        // random blocks with short random gaps
        repeat (random_blocks) begin
            fill_random_block(0, 256);
            send_block();
            idle_cycles($unsigned($random(seed)) % (max_gap + 1));
        end
        run_readout();
        finish_test("accumulate");

        // second readout sees cleared accumulators
        run_readout();
        // partial block is dropped by read_out
        fill_random_block(0, 256);
        for (int s = 0; s < slices - 1; s++) begin
            drive_strobe(pend_codes[s], pend_acts[s]);
        end
        run_readout();
        fill_random_block(0, 256);
        send_block();
        run_readout();
        finish_test("clear");

        // walk through codes 243..255
        for (int i = 0; i < invalid_rounds; i++) begin
            fill_random_block(0, 256);
            for (int s = 0; s < slices; s++) begin
                pend_codes[s] = weight_code_t'(max_weight_code + 1 + (i * slices + s) % 13);
            end
            repeat (repeat_blocks) send_block();
            run_readout();
        end
        finish_test("invalid codes");

        // in_valid high every cycle
        repeat (burst_blocks) begin
            fill_random_block(0, 256);
            send_block();
        end
        run_readout();
        finish_test("back to back");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tests
verilog/ternary_pkg.sv
verilog/ternary_unpack.sv
verilog/block_gatherer.sv
verilog/mac_array.sv
verilog/readout_queue.sv
verilog/ternary_matmul_top.sv
tests/ternary_matmul_tb.sv
